//--- source/mem_pkg.sv
package mem_pkg;

    // Data path and address width
    localparam int DATA_W = 32;

    // log2 of the RAM depth in words
    localparam int RAM_AW_DEFAULT = 8;

    // Exception bus layout
    localparam int EXCEPT_W = 9;
    localparam int except_adel = 1; // Load address error
    localparam int except_ades = 0; // Store address error

    typedef logic [EXCEPT_W-1:0] except_t;

    // Memory operation codes, six bits like the pipeline op field
    typedef enum logic [5:0] {
        op_none = 6'h00,
        op_lb   = 6'h20,
        op_lh   = 6'h21,
        op_lw   = 6'h23,
        op_lbu  = 6'h24,
        op_lhu  = 6'h25,
        op_sb   = 6'h28,
        op_sh   = 6'h29,
        op_sw   = 6'h2b
    } mem_op_t;

endpackage

//--- source/mem_access.sv
module mem_access import mem_pkg::*; (
    input  logic              mem_en,
    input  mem_op_t           mem_op,
    input  logic [DATA_W-1:0] mem_addr,
    input  logic [DATA_W-1:0] mem_wdata,
    output logic [DATA_W-1:0] load_data,

    input  logic [DATA_W-1:0] ram_rdata,
    output logic              ram_en,
    output logic [3:0]        ram_wen,
    output logic [DATA_W-1:0] ram_addr,
    output logic [DATA_W-1:0] ram_wdata,

    input  logic              master_mem_sel,
    input  logic              slave_mem_sel,
    input  except_t           master_except_in,
    input  except_t           slave_except_in,
    output except_t           master_except,
    output except_t           slave_except,
    output logic              addr_err
);

    logic       adel;
    logic       ades;
    logic [3:0] wen_lane;
    logic [7:0] rd_byte;
    logic [15:0] rd_half;
    logic       master_clean;
    logic       slave_clean;

    // Lanes picked by the low address bits
    assign rd_byte = ram_rdata[8*mem_addr[1:0] +: 8];
    assign rd_half = mem_addr[1] ? ram_rdata[31:16] : ram_rdata[15:0];

    always_comb begin
        adel      = 1'b0;
        ades      = 1'b0;
        wen_lane  = 4'b0000;
        load_data = '0;
        ram_wdata = '0;
        case (mem_op)
            op_lw: begin
                adel = mem_addr[1:0] != 2'b00;
                if (!adel)
                    load_data = ram_rdata;
            end
            op_lh: begin
                adel = mem_addr[0];
                if (!adel)
                    load_data = {{16{rd_half[15]}}, rd_half}; // Sign extend
            end
            op_lhu: begin
                adel = mem_addr[0];
                if (!adel)
                    load_data = {16'h0000, rd_half};
            end
            op_lb: begin
                load_data = {{24{rd_byte[7]}}, rd_byte};
            end
            op_lbu: begin
                load_data = {24'h000000, rd_byte};
            end
            op_sw: begin
                ades      = mem_addr[1:0] != 2'b00;
                ram_wdata = mem_wdata;
                if (!ades)
                    wen_lane = 4'b1111;
            end
            op_sh: begin
                ades      = mem_addr[0];
                ram_wdata = {2{mem_wdata[15:0]}}; // Half-word on both lanes
                if (!ades)
                    wen_lane = mem_addr[1] ? 4'b1100 : 4'b0011;
            end
            op_sb: begin
                ram_wdata = {4{mem_wdata[7:0]}};
                wen_lane  = 4'b0001 << mem_addr[1:0];
            end
            default: begin
                wen_lane = 4'b0000;
            end
        endcase
    end

    // Address errors land only on the slot that owns the access
    always_comb begin
        master_except = master_except_in;
        slave_except  = slave_except_in;
        master_except[except_adel] = master_mem_sel & adel;
        master_except[except_ades] = master_mem_sel & ades;
        slave_except[except_adel]  = slave_mem_sel & adel;
        slave_except[except_ades]  = slave_mem_sel & ades;
    end

    assign master_clean = ~(|master_except);
    assign slave_clean  = ~(|slave_except);

    // An older-slot fault also blocks the younger slot
    assign ram_en = mem_en && ((master_mem_sel && master_clean) ||
                               (slave_mem_sel && master_clean && slave_clean));
    assign ram_wen  = wen_lane & {4{ram_en}};
    assign ram_addr = mem_addr;

    assign addr_err = master_except[except_adel] | master_except[except_ades] |
                      slave_except[except_adel] | slave_except[except_ades];

    always_comb begin
        if (ram_wen != 4'b0000)
            a_wen_store: assert (mem_op inside {op_sw, op_sh, op_sb})
                else $error("ram_wen set for non-store op %0h", mem_op);
    end

endmodule

//--- source/data_ram.sv
module data_ram import mem_pkg::*; #(
    parameter int RAM_AW = RAM_AW_DEFAULT
) (
    input  logic              clk,
    input  logic              ram_en,
    input  logic [3:0]        ram_wen,
    input  logic [DATA_W-1:0] ram_addr,
    input  logic [DATA_W-1:0] ram_wdata,
    output logic [DATA_W-1:0] ram_rdata
);

    localparam int DEPTH = 2 ** RAM_AW;

    logic [DATA_W-1:0] mem [DEPTH];
    logic [RAM_AW-1:0] word_idx;

    assign word_idx = ram_addr[RAM_AW+1:2]; // Word address

    // Blocked accesses read back zero
    assign ram_rdata = ram_en ? mem[word_idx] : '0;

    always_ff @(posedge clk) begin
        if (ram_en) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (ram_wen[lane])
                    mem[word_idx][8*lane +: 8] <= ram_wdata[8*lane +: 8];
            end
        end
    end

    // Access gating upstream must clear the lanes too
    a_no_wen_when_off: assert property (
        @(posedge clk) !ram_en |-> ram_wen == 4'b0000
    ) else $error("ram_wen %b with ram_en low", ram_wen);

endmodule

//--- source/mem_wb_reg.sv
module mem_wb_reg import mem_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              mem_en,
    input  logic [DATA_W-1:0] load_data,
    input  except_t           master_except,
    input  except_t           slave_except,
    output logic              wb_valid,
    output logic [DATA_W-1:0] wb_rdata,
    output except_t           wb_master_except,
    output except_t           wb_slave_except
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid         <= 1'b0;
            wb_rdata         <= '0;
            wb_master_except <= '0;
            wb_slave_except  <= '0;
        end else begin
            wb_valid         <= mem_en; // Marks a live slot in writeback
            wb_rdata         <= load_data;
            wb_master_except <= master_except;
            wb_slave_except  <= slave_except;
        end
    end

endmodule

//--- source/addr_err_log.sv
module addr_err_log import mem_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              addr_err,
    input  logic [DATA_W-1:0] mem_addr,
    input  logic              err_clr,
    output logic              err_seen,
    output logic [DATA_W-1:0] bad_vaddr
);

    logic capture;

    // A fault in the clearing cycle takes the slot
    assign capture = addr_err && (!err_seen || err_clr);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            err_seen  <= 1'b0;
            bad_vaddr <= '0;
        end else if (capture) begin
            err_seen  <= 1'b1;
            bad_vaddr <= mem_addr;
        end else if (err_clr) begin
            err_seen  <= 1'b0;
        end
    end

    // First faulting address is held until released
    a_hold_vaddr: assert property (
        @(posedge clk) disable iff (!rst_n)
        err_seen && !err_clr |=> $stable(bad_vaddr)
    ) else $error("bad_vaddr changed while held");

endmodule

//--- source/mem_subsystem.sv
module mem_subsystem import mem_pkg::*; #(
    parameter int RAM_AW = RAM_AW_DEFAULT
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              mem_en,
    input  mem_op_t           mem_op,
    input  logic [DATA_W-1:0] mem_addr,
    input  logic [DATA_W-1:0] mem_wdata,
    input  logic              master_mem_sel,
    input  logic              slave_mem_sel,
    input  except_t           master_except_in,
    input  except_t           slave_except_in,
    input  logic              err_clr,
    output logic              wb_valid,
    output logic [DATA_W-1:0] wb_rdata,
    output except_t           wb_master_except,
    output except_t           wb_slave_except,
    output logic              err_seen,
    output logic [DATA_W-1:0] bad_vaddr
);

    logic [DATA_W-1:0] load_data;
    logic              ram_en;
    logic [3:0]        ram_wen;
    logic [DATA_W-1:0] ram_addr;
    logic [DATA_W-1:0] ram_wdata;
    logic [DATA_W-1:0] ram_rdata;
    except_t           master_except;
    except_t           slave_except;
    logic              addr_err;

    mem_access mem_access_i (
        .mem_en           (mem_en),
        .mem_op           (mem_op),
        .mem_addr         (mem_addr),
        .mem_wdata        (mem_wdata),
        .load_data        (load_data),
        .ram_rdata        (ram_rdata),
        .ram_en           (ram_en),
        .ram_wen          (ram_wen),
        .ram_addr         (ram_addr),
        .ram_wdata        (ram_wdata),
        .master_mem_sel   (master_mem_sel),
        .slave_mem_sel    (slave_mem_sel),
        .master_except_in (master_except_in),
        .slave_except_in  (slave_except_in),
        .master_except    (master_except),
        .slave_except     (slave_except),
        .addr_err         (addr_err)
    );

    data_ram #(
        .RAM_AW (RAM_AW)
    ) data_ram_i (
        .clk       (clk),
        .ram_en    (ram_en),
        .ram_wen   (ram_wen),
        .ram_addr  (ram_addr),
        .ram_wdata (ram_wdata),
        .ram_rdata (ram_rdata)
    );

    mem_wb_reg mem_wb_reg_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .mem_en           (mem_en),
        .load_data        (load_data),
        .master_except    (master_except),
        .slave_except     (slave_except),
        .wb_valid         (wb_valid),
        .wb_rdata         (wb_rdata),
        .wb_master_except (wb_master_except),
        .wb_slave_except  (wb_slave_except)
    );

    addr_err_log addr_err_log_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .addr_err  (addr_err),
        .mem_addr  (mem_addr),
        .err_clr   (err_clr),
        .err_seen  (err_seen),
        .bad_vaddr (bad_vaddr)
    );

endmodule

//--- tb/tb_mem_subsystem.sv
module tb_mem_subsystem import mem_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES = 10;

    typedef struct packed {
        int          test;
        mem_op_t     op;
        logic [31:0] addr;
        logic [31:0] wdata;
        int          slot; // 0 none, 1 master, 2 slave
        except_t     mexc;
        except_t     sexc;
        logic        en;
        logic        clr;
    } row_t;

    logic              clk;
    logic              rst_n;
    logic              mem_en;
    mem_op_t           mem_op;
    logic [DATA_W-1:0] mem_addr;
    logic [DATA_W-1:0] mem_wdata;
    logic              master_mem_sel;
    logic              slave_mem_sel;
    except_t           master_except_in;
    except_t           slave_except_in;
    logic              err_clr;
    logic              wb_valid;
    logic [DATA_W-1:0] wb_rdata;
    except_t           wb_master_except;
    except_t           wb_slave_except;
    logic              err_seen;
    logic [DATA_W-1:0] bad_vaddr;

    row_t        rows[$];
    logic [7:0]  ref_mem [1024]; // Byte image of the 256-word RAM
    logic [15:0] lfsr_state;
    logic        ref_seen;
    logic [31:0] ref_vaddr;
    logic        exp_valid;
    logic [31:0] exp_rdata;
    except_t     exp_mexc;
    except_t     exp_sexc;
    int          err_count;
    int          check_count;
    int          test_errs [6];
    int          watchdog_ns;
    logic        table_ready = 1'b0;
    string       test_names [6] = '{"wb_valid low in reset", "aligned stores and loads",
                                    "misaligned faults", "incoming exceptions",
                                    "wb_valid follows mem_en", "bad_vaddr capture and clear"};

    mem_subsystem #(.RAM_AW(8)) mem_subsystem_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            val = {val[30:0], lfsr_state[0]};
        end
    endtask

    task automatic add_row(input int test, input mem_op_t op, input logic [31:0] addr,
                           input logic [31:0] wdata, input int slot, input except_t mexc,
                           input except_t sexc, input logic en, input logic clr);
        rows.push_back(row_t'{test, op, addr, wdata, slot, mexc, sexc, en, clr});
    endtask

    task automatic build_table();
        logic [31:0] rnd;
        logic [31:0] waddr [3];

        for (int k = 0; k < 3; k++) begin
            take_bits(8, rnd);
            waddr[k] = {22'd0, rnd[7:0], 2'b00}; // Random word, aligned
            take_bits(32, rnd);
            add_row(1, op_sw, waddr[k], rnd, 1, '0, '0, 1'b1, 1'b0);
        end
        for (int k = 0; k < 4; k++) begin
            take_bits(8, rnd);
            add_row(1, op_sb, waddr[0] + 32'(k), rnd, k % 2 + 1, '0, '0, 1'b1, 1'b0);
        end
        for (int k = 0; k < 2; k++) begin
            take_bits(16, rnd);
            add_row(1, op_sh, waddr[1] + 32'(2 * k), rnd, 2, '0, '0, 1'b1, 1'b0);
        end
        for (int k = 0; k < 3; k++)
            add_row(1, op_lw, waddr[k], '0, 1, '0, '0, 1'b1, 1'b0);
        add_row(1, op_sw, 32'h080, 32'h80ff7f01, 1, '0, '0, 1'b1, 1'b0); // Both sign polarities
        for (int k = 0; k < 4; k++) begin
            add_row(1, op_lb, waddr[0] + 32'(k), '0, 1, '0, '0, 1'b1, 1'b0);
            add_row(1, op_lbu, 32'h080 + 32'(k), '0, 2, '0, '0, 1'b1, 1'b0);
            add_row(1, op_lb, 32'h080 + 32'(k), '0, 2, '0, '0, 1'b1, 1'b0);
        end
        for (int k = 0; k < 2; k++) begin
            add_row(1, op_lh, waddr[1] + 32'(2 * k), '0, 2, '0, '0, 1'b1, 1'b0);
            add_row(1, op_lhu, 32'h080 + 32'(2 * k), '0, 1, '0, '0, 1'b1, 1'b0);
            add_row(1, op_lh, 32'h080 + 32'(2 * k), '0, 1, '0, '0, 1'b1, 1'b0);
        end
        add_row(2, op_sw, 32'h100, 32'h11223344, 1, '0, '0, 1'b1, 1'b0);
        add_row(2, op_lw, 32'h101, '0, 1, '0, '0, 1'b1, 1'b0);
        add_row(2, op_lh, 32'h103, '0, 2, '0, '0, 1'b1, 1'b0);
        add_row(2, op_lhu, 32'h101, '0, 1, '0, '0, 1'b1, 1'b0);
        add_row(2, op_sw, 32'h102, 32'hdeadbeef, 1, '0, '0, 1'b1, 1'b0);
        add_row(2, op_sh, 32'h101, 32'h0000cafe, 2, '0, '0, 1'b1, 1'b0);
        add_row(2, op_sw, 32'h103, 32'h0badf00d, 2, '0, '0, 1'b1, 1'b0);
        add_row(2, op_lw, 32'h100, '0, 1, '0, '0, 1'b1, 1'b0);
        add_row(2, op_lb, 32'h103, '0, 2, '0, '0, 1'b1, 1'b0);
        add_row(3, op_sw, 32'h180, 32'ha5a5a5a5, 1, '0, '0, 1'b1, 1'b0);
        add_row(3, op_sw, 32'h180, 32'h12345678, 1, 9'h004, '0, 1'b1, 1'b0);
        add_row(3, op_sh, 32'h182, 32'h00005555, 2, '0, 9'h020, 1'b1, 1'b0);
        add_row(3, op_sb, 32'h181, 32'h00000066, 2, 9'h100, '0, 1'b1, 1'b0);
        add_row(3, op_lw, 32'h180, '0, 2, 9'h008, '0, 1'b1, 1'b0);
        add_row(3, op_lw, 32'h180, '0, 1, '0, '0, 1'b1, 1'b0);
        add_row(4, op_none, '0, '0, 0, '0, '0, 1'b0, 1'b0);
        add_row(4, op_lw, 32'h100, '0, 1, '0, '0, 1'b1, 1'b0);
        add_row(4, op_lw, 32'h100, '0, 1, '0, '0, 1'b0, 1'b0);
        add_row(4, op_none, '0, '0, 0, '0, '0, 1'b1, 1'b0);
        add_row(4, op_none, '0, '0, 0, '0, '0, 1'b0, 1'b0);
        add_row(5, op_lw, 32'h100, '0, 1, '0, '0, 1'b1, 1'b1);
        add_row(5, op_lw, 32'h201, '0, 1, '0, '0, 1'b1, 1'b0);
        add_row(5, op_sw, 32'h302, 32'h01020304, 2, '0, '0, 1'b1, 1'b0);
        take_bits(10, rnd);
        add_row(5, op_lh, {22'd0, rnd[9:1], 1'b1}, '0, 1, '0, '0, 1'b1, 1'b0);
        add_row(5, op_lw, 32'h180, '0, 1, '0, '0, 1'b1, 1'b0);
        add_row(5, op_none, '0, '0, 0, '0, '0, 1'b1, 1'b1);
        add_row(5, op_sh, 32'h0a5, 32'h00001234, 2, '0, '0, 1'b1, 1'b0);
        add_row(5, op_lhu, 32'h1c3, '0, 1, '0, '0, 1'b1, 1'b1); // Fault and clear together
        add_row(5, op_lw, 32'h100, '0, 1, '0, '0, 1'b1, 1'b0);
    endtask

    task automatic model_row(input row_t r);
        logic [7:0]  widx;
        logic [1:0]  lane;
        logic [31:0] word;
        logic [15:0] half;
        logic [7:0]  bsel;
        logic        mis;
        logic        adel;
        logic        ades;
        logic        ram_on;

        widx = r.addr[9:2];
        lane = r.addr[1:0];
        mis  = (r.op inside {op_lw, op_sw} && lane != 2'b00) ||
               (r.op inside {op_lh, op_lhu, op_sh} && lane[0]);
        adel = mis && r.op inside {op_lw, op_lh, op_lhu};
        ades = mis && r.op inside {op_sw, op_sh};
        exp_mexc = {r.mexc[8:2], r.slot == 1 && adel, r.slot == 1 && ades};
        exp_sexc = {r.sexc[8:2], r.slot == 2 && adel, r.slot == 2 && ades};
        // Older slot faults block the younger slot too
        ram_on = r.en && exp_mexc == '0 && (r.slot == 1 || (r.slot == 2 && exp_sexc == '0));
        word = ram_on ? {ref_mem[{widx, 2'd3}], ref_mem[{widx, 2'd2}],
                         ref_mem[{widx, 2'd1}], ref_mem[{widx, 2'd0}]} : '0;
        half = lane[1] ? word[31:16] : word[15:0];
        bsel = ram_on ? ref_mem[{widx, lane}] : 8'h00;
        case (r.op)
            op_lw:   exp_rdata = mis ? '0 : word;
            op_lh:   exp_rdata = mis ? '0 : {{16{half[15]}}, half};
            op_lhu:  exp_rdata = mis ? '0 : {16'h0000, half};
            op_lb:   exp_rdata = {{24{bsel[7]}}, bsel};
            op_lbu:  exp_rdata = {24'h000000, bsel};
            default: exp_rdata = '0;
        endcase
        if (ram_on && !mis) begin
            case (r.op)
                op_sw: begin
                    for (int k = 0; k < 4; k++)
                        ref_mem[{widx, 2'(k)}] = r.wdata[8*k +: 8];
                end
                op_sh: begin
                    ref_mem[{widx, lane[1], 1'b0}] = r.wdata[7:0];
                    ref_mem[{widx, lane[1], 1'b1}] = r.wdata[15:8];
                end
                op_sb:   ref_mem[{widx, lane}] = r.wdata[7:0];
                default: ;
            endcase
        end
        exp_valid = r.en;
        if (|{exp_mexc[1:0], exp_sexc[1:0]} && (!ref_seen || r.clr)) begin
            ref_seen  = 1'b1;
            ref_vaddr = r.addr;
        end else if (r.clr) begin
            ref_seen = 1'b0;
        end
    endtask

    task automatic check_val(input int test, input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        check_count++;
        assert (got === exp) else begin
            $display("CHECK FAILED at %0d ns: %s = %h, expected %h", $time, name, got, exp);
            err_count++;
            test_errs[test]++;
        end
    endtask

    task automatic check_outputs(input int test);
        check_val(test, "wb_valid", 32'(wb_valid), 32'(exp_valid));
        check_val(test, "wb_rdata", wb_rdata, exp_rdata);
        check_val(test, "wb_master_except", 32'(wb_master_except), 32'(exp_mexc));
        check_val(test, "wb_slave_except", 32'(wb_slave_except), 32'(exp_sexc));
        check_val(test, "err_seen", 32'(err_seen), 32'(ref_seen));
        check_val(test, "bad_vaddr", bad_vaddr, ref_vaddr);
    endtask

    initial begin
        wait (table_ready);
        #(watchdog_ns);
        $display("Watchdog expired after %0d ns before all rows were applied", watchdog_ns);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        err_count        = 0;
        check_count      = 0;
        test_errs        = '{default: 0};
        lfsr_state       = 16'd65;
        ref_seen         = 1'b0;
        ref_vaddr        = '0;
        exp_valid        = 1'b0;
        exp_rdata        = '0;
        exp_mexc         = '0;
        exp_sexc         = '0;
        rst_n            = 1'b0;
        mem_en           = 1'b1; // Live request held during reset
        mem_op           = op_none;
        mem_addr         = '0;
        mem_wdata        = '0;
        master_mem_sel   = 1'b1;
        slave_mem_sel    = 1'b0;
        master_except_in = '0;
        slave_except_in  = '0;
        err_clr          = 1'b0;
        build_table();
        watchdog_ns = (rows.size() + RESET_CYCLES + 20) * 4;
        table_ready = 1'b1;
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_outputs(0);
        end
        $display("test 0 (%s): %0d errors", test_names[0], test_errs[0]);
        rst_n = 1'b1;
        foreach (rows[i]) begin
            mem_en           = rows[i].en;
            mem_op           = rows[i].op;
            mem_addr         = rows[i].addr;
            mem_wdata        = rows[i].wdata;
            master_mem_sel   = rows[i].slot == 1;
            slave_mem_sel    = rows[i].slot == 2;
            master_except_in = rows[i].mexc;
            slave_except_in  = rows[i].sexc;
            err_clr          = rows[i].clr;
            model_row(rows[i]);
            @(negedge clk);
            check_outputs(rows[i].test);
            if (i == rows.size() - 1 || rows[i + 1].test != rows[i].test)
                $display("test %0d (%s): %0d errors", rows[i].test,
                         test_names[rows[i].test], test_errs[rows[i].test]);
        end
        $display("%0d rows, %0d checks, %0d errors", rows.size(), check_count, err_count);
        if (err_count == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

//--- files.f
source/mem_pkg.sv
source/mem_access.sv
source/data_ram.sv
source/mem_wb_reg.sv
source/addr_err_log.sv
source/mem_subsystem.sv
tb/tb_mem_subsystem.sv

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_mem_subsystem -f files.f -o tb_sim \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    || echo "build or simulation exited with an error"
cat sim.log 2>/dev/null
grep -qx "TEST PASS" sim.log 2>/dev/null && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
